// ==== tests/cache_stim.txt ====
# op address write_line byte_enables expected_line memory_reads memory_writes
# for a write, expected_line is the memory line after the write
r 00000100 0 0 1003efc31002efc31001efc31000efc3 1 0
r 00000100 0 0 1003efc31002efc31001efc31000efc3 0 0
r 00000108 0 0 1003efc31002efc31001efc31000efc3 0 0
w 00000100 11111111222222223333333344444444 00ff 1003efc31002efc33333333344444444 0 1
r 00000100 0 0 1003efc31002efc33333333344444444 0 0
w 00000200 aaaaaaaabbbbbbbbccccccccdddddddd ffff aaaaaaaabbbbbbbbccccccccdddddddd 0 1
r 00000200 0 0 aaaaaaaabbbbbbbbccccccccdddddddd 1 0
r 00000200 0 0 aaaaaaaabbbbbbbbccccccccdddddddd 0 0
r 20000040 0 0 0403fbc30402fbc30401fbc30400fbc3 1 0
r 20000040 0 0 0403fbc30402fbc30401fbc30400fbc3 1 0
w 20000040 55555555666666667777777788888888 f00f 555555550402fbc30401fbc388888888 0 1
r 20000040 0 0 555555550402fbc30401fbc388888888 1 0
r 00000500 0 0 5003afc35002afc35001afc35000afc3 1 0
r 00000100 0 0 1003efc31002efc33333333344444444 1 0
r 00000500 0 0 5003afc35002afc35001afc35000afc3 1 0
r 00000500 0 0 5003afc35002afc35001afc35000afc3 0 0
w 00000100 0123456789abcdef0123456789abcdef ffff 0123456789abcdef0123456789abcdef 0 1
r 00000500 0 0 5003afc35002afc35001afc35000afc3 0 0
r 00000100 0 0 0123456789abcdef0123456789abcdef 1 0
r 00000330 0 0 3303ccc33302ccc33301ccc33300ccc3 1 0

// ==== compile.f ====
+incdir+design
design/cache_addr_pkg.sv
design/cache_bus_pkg.sv
design/cache_routing.sv
design/cache_controller.sv
design/cache_top.sv
tests/cache_tb.sv

// ==== Makefile ====
TOP := cache_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing -f compile.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tests/cache_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_defines.svh"

module cache_tb;

	logic                          clk;
	logic                          rst_n;
	logic [31:0]                   core_address;
	logic                          core_read;
	logic                          core_write;
	logic [`CACHE_LINE_BITS-1:0]   core_writedata_line;
	logic [`CACHE_BE_BITS-1:0]     core_byteenable_line;
	logic                          core_waitrequest;
	logic [`CACHE_LINE_BITS-1:0]   core_readdata_line;
	logic [31:0]                   mem_address;
	logic                          mem_read;
	logic                          mem_write;
	logic [`CACHE_LINE_BITS-1:0]   mem_writedata;
	logic [`CACHE_BE_BITS-1:0]     mem_byteenable;
	logic [`CACHE_LINE_BITS-1:0]   mem_readdata;
	logic                          mem_waitrequest;

	// Stimulus columns, one entry per access
	logic [7:0]   ops [$];
	logic [31:0]  addrs [$];
	logic [127:0] wlines [$];
	logic [15:0]  enables [$];
	logic [127:0] expected [$];
	int           exp_reads [$];
	int           exp_writes [$];

	// Memory model contents and its log of completed operations
	logic [127:0] mem_model [256];
	int           mem_reads;
	int           mem_writes;

	logic [7:0]   lfsr_state;
	int           error_count;
	int           watchdog_cycles;
	bit           stim_loaded;
	bit           load_ok;

	cache_top DUT (
		.clk, .rst_n,
		.core_address, .core_read, .core_write,
		.core_writedata_line, .core_byteenable_line,
		.core_waitrequest, .core_readdata_line,
		.mem_address, .mem_read, .mem_write, .mem_writedata, .mem_byteenable,
		.mem_readdata, .mem_waitrequest
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Galois form of x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);
	endfunction

	// One LFSR step for every bit handed out
	task automatic take_random_bits(input int count, output int value);
		value = 0;
		for (int b = 0; b < count; b++) begin
			value = (value << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// Every 32-bit word carries the line number, its own position and the inverted number
	function automatic logic [127:0] fill_line(input logic [7:0] idx);
		logic [127:0] l;
		for (int w = 0; w < 4; w++) begin
			l[32*w +: 32] = {idx, 8'(w), ~idx, 8'hc3};
		end
		return l;
	endfunction

	task automatic check_value(input string name, input logic [127:0] actual,
			input logic [127:0] want);
		if (actual !== want) begin
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, want);
			error_count++;
		end
	endtask

	task automatic load_stimulus(output bit ok);
		int           fd;
		int           code;
		logic [7:0]   op;
		logic [31:0]  addr;
		logic [127:0] wdata;
		logic [15:0]  be;
		logic [127:0] exp_line;
		int           nrd;
		int           nwr;
		logic [8*160-1:0] rest;
		fd = $fopen("tests/cache_stim.txt", "r");
		ok = 1'b0;
		if (fd != 0) begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, "%s", op);
				// Lines opening with a lone hash are column notes
				if (code == 1 && op == "#") begin
					code = $fgets(rest, fd);
				end else if (code == 1) begin
					code = $fscanf(fd, "%h %h %h %h %d %d", addr, wdata, be, exp_line, nrd, nwr);
					if (code == 6) begin
						ops.push_back(op);
						addrs.push_back(addr);
						wlines.push_back(wdata);
						enables.push_back(be);
						expected.push_back(exp_line);
						exp_reads.push_back(nrd);
						exp_writes.push_back(nwr);
					end else begin
						$display("Stimulus line %0d is incomplete", ops.size() + 1);
						error_count++;
					end
				end
			end
			$fclose(fd);
			ok = (ops.size() > 0);
		end
	endtask

	// Drives one access and waits mid-cycle until core_waitrequest is low
	task automatic run_access(input int n);
		int           reads_before;
		int           writes_before;
		int           wait_cycles;
		logic [127:0] got;
		reads_before = mem_reads;
		writes_before = mem_writes;
		core_address = addrs[n];
		core_read = (ops[n] == "r");
		core_write = (ops[n] == "w");
		core_writedata_line = wlines[n];
		core_byteenable_line = enables[n];
		if (!core_read && !core_write) begin
			$display("Stimulus line %0d has an unknown opcode", n + 1);
			error_count++;
		end else begin
			// Counts the cycles up to and including the one where waitrequest is low
			wait_cycles = 1;
			@(negedge clk);
			while (core_waitrequest) begin
				@(negedge clk);
				wait_cycles++;
			end
			got = core_readdata_line;
			@(posedge clk);
			#2;
			core_read = 1'b0;
			core_write = 1'b0;
			// A write is judged by the memory line it leaves behind
			if (ops[n] == "r") begin
				check_value("core_readdata_line", got, expected[n]);
			end else begin
				check_value("mem_model line", mem_model[addrs[n][11:4]], expected[n]);
			end
			check_value("memory reads", 128'(mem_reads - reads_before), 128'(exp_reads[n]));
			check_value("memory writes", 128'(mem_writes - writes_before), 128'(exp_writes[n]));
			// A read that needs no memory is a hit and completes in two cycles
			if (ops[n] == "r" && exp_reads[n] == 0) begin
				check_value("read hit cycles", 128'(wait_cycles), 128'd2);
			end
		end
	endtask

	// Memory model with a random stall of 0 to 3 cycles per request
	initial begin
		int         stall;
		logic [7:0] idx;
		mem_waitrequest = 1'b1;
		mem_readdata = '0;
		for (int i = 0; i < 256; i++) begin
			mem_model[i] = fill_line(8'(i));
		end
		forever begin
			@(posedge clk);
			#2;
			if (rst_n && (mem_read || mem_write)) begin
				take_random_bits(2, stall);
				repeat (stall) begin
					@(posedge clk);
					#2;
				end
				idx = mem_address[11:4];
				// Every memory operation serves the pending core access at its line address
				check_value("mem_address", mem_address,
					{core_address[31:`CACHE_OFFSET_BITS], {`CACHE_OFFSET_BITS{1'b0}}});
				// Uncached accesses carry the core's own byte enables
				if (core_address[31 -: `CACHE_IO_BITS] != '0) begin
					check_value("mem_byteenable", mem_byteenable, core_byteenable_line);
				end
				if (mem_read) begin
					mem_readdata = mem_model[idx];
					mem_reads++;
				end else begin
					for (int b = 0; b < 16; b++) begin
						if (mem_byteenable[b]) begin
							mem_model[idx][8*b +: 8] = mem_writedata[8*b +: 8];
						end
					end
					mem_writes++;
				end
				// Transfer completes at the next edge
				mem_waitrequest = 1'b0;
				@(posedge clk);
				#2;
				mem_waitrequest = 1'b1;
			end
		end
	end

	initial begin
		wait (stim_loaded);
		repeat (watchdog_cycles) @(posedge clk);
		$display("Timeout: the accesses did not complete within %0d clock cycles",
			watchdog_cycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		core_address = '0;
		core_read = 1'b0;
		core_write = 1'b0;
		core_writedata_line = '0;
		core_byteenable_line = '0;
		lfsr_state = 8'd51;
		error_count = 0;
		mem_reads = 0;
		mem_writes = 0;
		load_stimulus(load_ok);
		watchdog_cycles = ops.size() * 20;
		if (!load_ok) begin
			$display("Could not read any access from tests/cache_stim.txt");
			$display("TESTBENCH FAILED");
		end else begin
			stim_loaded = 1'b1;
			repeat (5) @(posedge clk);
			#2;
			rst_n = 1'b1;
			for (int n = 0; n < ops.size(); n++) begin
				run_access(n);
			end
			$display("Accesses run: %0d, errors: %0d", ops.size(), error_count);
			if (error_count == 0) begin
				$display("TESTBENCH PASSED");
			end else begin
				$display("TESTBENCH FAILED");
			end
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== design/cache_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_defines.svh"

module cache_top (
	input  logic                  clk,
	input  logic                  rst_n,

	input  cache_addr_pkg::ptr    core_address,
	input  logic                  core_read,
	input  logic                  core_write,
	input  cache_bus_pkg::line    core_writedata_line,
	input  cache_bus_pkg::line_be core_byteenable_line,
	output logic                  core_waitrequest,
	output cache_bus_pkg::line    core_readdata_line,

	output cache_addr_pkg::word   mem_address,
	output logic                  mem_read,
	output logic                  mem_write,
	output cache_bus_pkg::line    mem_writedata,
	output cache_bus_pkg::line_be mem_byteenable,
	input  cache_bus_pkg::line    mem_readdata,
	input  logic                  mem_waitrequest
);

	// Address fields and gated requests from the router to the controller
	cache_addr_pkg::addr_tag    core_tag;
	cache_addr_pkg::addr_index  core_index;
	cache_addr_pkg::addr_offset core_offset;
	logic                       cache_core_read;
	logic                       cache_core_write;
	cache_bus_pkg::line         data_rd;
	logic                       cache_core_waitrequest;

	// Memory side of the controller, arbitrated by the router
	cache_addr_pkg::word        cache_mem_address;
	logic                       cache_mem_read;
	logic                       cache_mem_write;
	cache_bus_pkg::line         cache_mem_writedata;
	logic                       cache_mem_waitrequest;

	cache_routing routing (
		.clk, .rst_n,
		.core_address, .core_read, .core_write,
		.core_writedata_line, .core_byteenable_line,
		.core_waitrequest, .core_readdata_line,
		.core_tag, .core_index, .core_offset,
		.data_rd, .cache_core_waitrequest, .cache_core_read, .cache_core_write,
		.cache_mem_address, .cache_mem_read, .cache_mem_write,
		.cache_mem_writedata, .cache_mem_waitrequest,
		.mem_waitrequest, .mem_readdata, .mem_address,
		.mem_read, .mem_write, .mem_writedata, .mem_byteenable
	);

	cache_controller controller (
		.clk, .rst_n,
		.core_tag, .core_index, .core_offset,
		.cache_core_read, .cache_core_write,
		.core_writedata_line, .core_byteenable_line,
		.data_rd, .cache_core_waitrequest,
		.cache_mem_address, .cache_mem_read, .cache_mem_write,
		.cache_mem_writedata, .cache_mem_waitrequest,
		.mem_readdata
	);

endmodule

`default_nettype wire

// ==== design/cache_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_defines.svh"

module cache_controller (
	input  logic                       clk,
	input  logic                       rst_n,

	input  cache_addr_pkg::addr_tag    core_tag,
	input  cache_addr_pkg::addr_index  core_index,
	input  cache_addr_pkg::addr_offset core_offset,
	input  logic                       cache_core_read,
	input  logic                       cache_core_write,
	input  cache_bus_pkg::line         core_writedata_line,
	input  cache_bus_pkg::line_be      core_byteenable_line,
	output cache_bus_pkg::line         data_rd,
	output logic                       cache_core_waitrequest,

	output cache_addr_pkg::word        cache_mem_address,
	output logic                       cache_mem_read,
	output logic                       cache_mem_write,
	output cache_bus_pkg::line         cache_mem_writedata,
	input  logic                       cache_mem_waitrequest,
	input  cache_bus_pkg::line         mem_readdata
);

	cache_bus_pkg::ctrl_state  state;

	// One valid bit, tag and line per entry
	logic [`CACHE_LINES-1:0]   valid;
	cache_addr_pkg::addr_tag   tags [`CACHE_LINES];
	cache_bus_pkg::line        lines [`CACHE_LINES];

	cache_addr_pkg::ptr        byte_addr;
	cache_addr_pkg::word       line_addr;
	cache_bus_pkg::line        stored_line;
	cache_bus_pkg::line        merged_line;
	logic                      hit;

	assign stored_line = lines[core_index];
	assign hit = valid[core_index] && (tags[core_index] == core_tag);

	// Cacheable addresses always have zero region bits
	assign byte_addr = {{`CACHE_IO_BITS{1'b0}}, core_tag, core_index, core_offset};

	// Memory works on whole lines, so the offset field is cleared
	assign line_addr = byte_addr & ~cache_addr_pkg::word'((1 << `CACHE_OFFSET_BITS) - 1);

	// Enabled bytes come from the core and the rest from the stored line
	always_comb begin
		for (int i = 0; i < `CACHE_BE_BITS; i++) begin
			merged_line[8*i +: 8] = core_byteenable_line[i] ?
				core_writedata_line[8*i +: 8] : stored_line[8*i +: 8];
		end
	end

	// The core completes only in RESPOND
	assign cache_core_waitrequest = (state != cache_bus_pkg::RESPOND);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= cache_bus_pkg::LOOKUP;
			valid <= '0;
			cache_mem_read <= 1'b0;
			cache_mem_write <= 1'b0;
		end else begin
			unique case (state)
				cache_bus_pkg::LOOKUP:
					if (cache_core_read && !hit) begin
						state <= cache_bus_pkg::REFILL;
						cache_mem_read <= 1'b1;
					end else if (cache_core_read) begin
						state <= cache_bus_pkg::RESPOND;
					end else if (cache_core_write) begin
						// Write-through for hits and misses alike
						state <= cache_bus_pkg::WRITE_THROUGH;
						cache_mem_write <= 1'b1;
					end
				cache_bus_pkg::REFILL:
					if (!cache_mem_waitrequest) begin
						state <= cache_bus_pkg::RESPOND;
						cache_mem_read <= 1'b0;
						valid[core_index] <= 1'b1;
					end
				cache_bus_pkg::WRITE_THROUGH:
					if (!cache_mem_waitrequest) begin
						state <= cache_bus_pkg::RESPOND;
						cache_mem_write <= 1'b0;
					end
				cache_bus_pkg::RESPOND:
					state <= cache_bus_pkg::LOOKUP;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			cache_bus_pkg::LOOKUP: begin
				// Whatever is captured on the last LOOKUP cycle stays put during the transfer
				cache_mem_address <= line_addr;
				// A miss sends the core line unchanged since nothing is allocated
				cache_mem_writedata <= hit ? merged_line : core_writedata_line;
				if (cache_core_read && hit) begin
					data_rd <= stored_line;
				end
				if (cache_core_write && hit) begin
					lines[core_index] <= merged_line;
				end
			end
			cache_bus_pkg::REFILL:
				// The refilled line also answers the pending read
				if (!cache_mem_waitrequest) begin
					lines[core_index] <= mem_readdata;
					tags[core_index] <= core_tag;
					data_rd <= mem_readdata;
				end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== design/cache_routing.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_defines.svh"

module cache_routing (
	input  logic                       clk,
	input  logic                       rst_n,

	input  cache_addr_pkg::ptr         core_address,
	input  logic                       core_read,
	input  logic                       core_write,
	input  cache_bus_pkg::line         core_writedata_line,
	input  cache_bus_pkg::line_be      core_byteenable_line,
	output logic                       core_waitrequest,
	output cache_bus_pkg::line         core_readdata_line,

	output cache_addr_pkg::addr_tag    core_tag,
	output cache_addr_pkg::addr_index  core_index,
	output cache_addr_pkg::addr_offset core_offset,

	input  cache_bus_pkg::line         data_rd,
	input  logic                       cache_core_waitrequest,
	output logic                       cache_core_read,
	output logic                       cache_core_write,

	input  cache_addr_pkg::word        cache_mem_address,
	input  logic                       cache_mem_read,
	input  logic                       cache_mem_write,
	input  cache_bus_pkg::line         cache_mem_writedata,
	output logic                       cache_mem_waitrequest,

	input  logic                       mem_waitrequest,
	input  cache_bus_pkg::line         mem_readdata,
	output cache_addr_pkg::word        mem_address,
	output logic                       mem_read,
	output logic                       mem_write,
	output cache_bus_pkg::line         mem_writedata,
	output cache_bus_pkg::line_be      mem_byteenable
);

	cache_bus_pkg::route_state  state;
	cache_addr_pkg::addr_io_region io;
	cache_addr_pkg::word        core_address_line;
	logic                       cached;
	logic                       cache_mem;
	logic                       start;

	// Split the core address into its four fields
	assign {io, core_tag, core_index, core_offset} = core_address;

	// Memory starts at zero and is a power of two in size, so any region bit set means I/O
	assign cached = (io == '0);

	// Line address for a bypassed access, region bits kept
	assign core_address_line = {io, core_tag, core_index, {`CACHE_OFFSET_BITS{1'b0}}};

	// Only cacheable requests reach the controller
	assign cache_core_read = core_read && cached;
	assign cache_core_write = core_write && cached;

	// The controller wants the memory port for a refill or a write-through
	assign cache_mem = cache_mem_read || cache_mem_write;

	// Steering of the read line back to the core
	assign core_readdata_line = cached ? data_rd : mem_readdata;

	always_comb begin
		start = 1'b0;
		core_waitrequest = cache_core_waitrequest;
		// The controller waits unless it owns the memory port
		cache_mem_waitrequest = 1'b1;

		unique case (state)
			cache_bus_pkg::IDLE:
				// A controller request or an uncached core access opens a transaction
				start = cache_mem || (!cached && (core_read || core_write));
			cache_bus_pkg::CACHE:
				cache_mem_waitrequest = mem_waitrequest;
			cache_bus_pkg::BYPASS:
				// The core sees memory directly in a bypass
				core_waitrequest = mem_waitrequest;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= cache_bus_pkg::IDLE;
			mem_read <= 1'b0;
			mem_write <= 1'b0;
		end else begin
			unique case (state)
				cache_bus_pkg::IDLE:
					if (start) begin
						// The controller wins when both want the port
						state <= cache_mem ? cache_bus_pkg::CACHE : cache_bus_pkg::BYPASS;
						mem_read <= cache_mem ? cache_mem_read : core_read;
						mem_write <= cache_mem ? cache_mem_write : core_write;
					end
				cache_bus_pkg::CACHE, cache_bus_pkg::BYPASS:
					// Memory accepted the transfer at this edge
					if (!mem_waitrequest) begin
						state <= cache_bus_pkg::IDLE;
						mem_read <= 1'b0;
						mem_write <= 1'b0;
					end
			endcase
		end
	end

	// Address and data are captured once and held while memory stalls
	always_ff @(posedge clk) begin
		if (start) begin
			mem_address <= cache_mem ? cache_mem_address : core_address_line;
			mem_writedata <= cache_mem ? cache_mem_writedata : core_writedata_line;
			// Cache traffic always moves whole lines
			mem_byteenable <= cache_mem ? {`CACHE_BE_BITS{1'b1}} : core_byteenable_line;
		end
	end

endmodule

`default_nettype wire

// ==== design/cache_bus_pkg.sv ====
`default_nettype none

`include "cache_defines.svh"

package cache_bus_pkg;

	// One full line of data on any port
	typedef logic [`CACHE_LINE_BITS-1:0] line;

	// Byte enables that go with a line
	typedef logic [`CACHE_BE_BITS-1:0] line_be;

	// Owner of the memory port in the router
	// CACHE serves the controller, BYPASS serves an uncached core access
	typedef enum logic [1:0] {
		IDLE,
		CACHE,
		BYPASS
	} route_state;

	// Controller sequence for one core access
	// LOOKUP always comes first and RESPOND always comes last
	typedef enum logic [1:0] {
		LOOKUP,
		REFILL,
		WRITE_THROUGH,
		RESPOND
	} ctrl_state;

endpackage

`default_nettype wire

// ==== design/cache_addr_pkg.sv ====
`default_nettype none

`include "cache_defines.svh"

package cache_addr_pkg;

	// Byte address as issued by the core
	typedef logic [31:0] ptr;

	// Line address on the memory port
	// The offset field of this address is always zero
	typedef logic [31:0] word;

	// Fields of a core address, from the top bit down
	// Region bits sit above the tag and are not stored in the cache
	typedef logic [`CACHE_IO_BITS-1:0] addr_io_region;

	// Stored next to each line and compared on every lookup
	typedef logic [`CACHE_TAG_BITS-1:0] addr_tag;

	// Picks the one entry that may hold the line
	typedef logic [`CACHE_INDEX_BITS-1:0] addr_index;

	// Position of a byte within the line
	// Accesses are line wide, so this only matters when forming addresses
	typedef logic [`CACHE_OFFSET_BITS-1:0] addr_offset;

endpackage

`default_nettype wire

// ==== design/cache_defines.svh ====
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Width of one cache line as seen by the core and by memory
`define CACHE_LINE_BITS 128

// One enable per byte of a line
`define CACHE_BE_BITS 16

// Top address bits that select the I/O region
// Zero here means the address is backed by cacheable memory
`define CACHE_IO_BITS 3

// The tag takes whatever is left between the region and the index
`define CACHE_TAG_BITS 19

// Selects one of the direct-mapped entries
`define CACHE_INDEX_BITS 6

// Byte position within a line, always zero on the memory side
`define CACHE_OFFSET_BITS 4

// Number of entries, must equal 2 ** CACHE_INDEX_BITS
`define CACHE_LINES 64

`endif
